/* files.f */
+incdir+design
+incdir+verif
design/pix_pkg.sv
design/ram_pkg.sv
design/pix_capture.sv
design/pix_fifo.sv
design/ram_controller.sv
design/pix_controller.sv
verif/pix_tb.sv

/* run.sh */
#!/bin/sh
# Build and run pix_tb, the exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module pix_tb -f files.f -o pix_tb_sim &&
./obj_dir/pix_tb_sim ||
{ echo "simulation run failed"; exit 1; }

/* verif/pix_tests.svh */
`ifndef PIX_TESTS_SVH
`define PIX_TESTS_SVH

// ==============================
// Command and readout helpers
// ==============================
task automatic issue_cmd(input cmd_op_t op, input int blk);
    @(posedge clk);
    #2;
    cmd.op      = op;
    cmd.block   = block_t'(blk);
    cmd_trigger = 1'b1;
    @(posedge clk);
    #2;
    cmd_trigger = 1'b0;
endtask

task automatic check_idle(input string name);
    @(negedge clk);
    check_value({name, " busy idle"}, 32'd0, 32'(busy));
    check_value({name, " readout_ready idle"}, 32'd0, 32'(readout_ready));
    check_value({name, " readout_done idle"}, 32'd0, 32'(readout_done));
endtask

task automatic wait_capture_done(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (busy && cycles < DONE_LIMIT) begin
        cycles++;
        @(negedge clk);
    end
    if (busy) abort_run({name, ": capture never finished, busy stayed high"});
    check_idle(name);
endtask

task automatic wait_ready(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!readout_ready && cycles < READY_LIMIT) begin
        cycles++;
        @(negedge clk);
    end
    if (!readout_ready) abort_run({name, ": readout_ready never rose"});
endtask

task automatic capture_block(input string name, input int blk);
    issue_cmd(op_capture, blk);
    @(negedge clk);
    check_value({name, " busy after capture command"}, 32'd1, 32'(busy));
    hold_sensor_idle(SETTLE_CYCLES);
    send_frame(blk, 1'b1);
    wait_capture_done(name);
endtask

task automatic read_block(input string name, input int blk, input bit stall);
    int    i;
    int    hold;
    word_t seen;
    issue_cmd(op_readout, blk);
    @(negedge clk);
    check_value({name, " busy after readout command"}, 32'd1, 32'(busy));
    for (i = 0; i < `IMAGE_WORDS; i++) begin
        wait_ready(name);
        check_value({name, " readout_done early"}, 32'd0, 32'(readout_done));
        seen = readout_data;
        check_value(name, 32'(expected[blk][i]), 32'(seen));
        if (stall) begin
            hold = $unsigned($random(seed)) % 4;
            repeat (hold) begin
                @(negedge clk);
                check_value({name, " ready held"}, 32'd1, 32'(readout_ready));
                check_value({name, " data held"}, 32'(expected[blk][i]),
                            32'(readout_data));
            end
        end
        @(posedge clk);
        #2;
        readout_trigger = 1'b1;
        @(posedge clk);
        #2;
        readout_trigger = 1'b0;
    end
    // Done pulses in the cycle after the last word is taken
    @(negedge clk);
    check_value({name, " readout_done"}, 32'd1, 32'(readout_done));
    check_idle(name);
endtask

// ==============================
// Directed tests
// ==============================
task automatic test_idle_outputs();
    check_idle("test_idle_outputs");
endtask

task automatic test_capture_readout();
    capture_block("test_capture_readout", 2);
    read_block("test_capture_readout", 2, 1'b0);
endtask

task automatic test_line_blanking();
    // Gap samples carry a marker that no recorded pixel can take
    mark_gaps = 1'b1;
    capture_block("test_line_blanking", 5);
    mark_gaps = 1'b0;
    read_block("test_line_blanking", 5, 1'b0);
endtask

task automatic test_skip_partial_frame();
    // Request lands two lines into a frame that is not recorded
    fork
        send_frame(3, 1'b0);
        begin
            repeat (FRAME_GAP + 2 * (LINE_PIXELS + LINE_GAP)) @(posedge pix_dclk);
            issue_cmd(op_capture, 3);
            @(negedge clk);
            check_value("test_skip_partial_frame busy after capture command", 32'd1,
                        32'(busy));
        end
    join
    send_frame(3, 1'b1);
    wait_capture_done("test_skip_partial_frame");
    read_block("test_skip_partial_frame", 3, 1'b0);
endtask

task automatic test_block_isolation();
    capture_block("test_block_isolation", 0);
    capture_block("test_block_isolation", 7);
    read_block("test_block_isolation block 0", 0, 1'b0);
    read_block("test_block_isolation block 7", 7, 1'b0);
    read_block("test_block_isolation block 2", 2, 1'b0);
endtask

task automatic test_readout_backpressure();
    read_block("test_readout_backpressure", 7, 1'b1);
endtask

`endif

/* verif/pix_tb.sv */
`default_nettype none

`include "pix_macros.svh"

module pix_tb import pix_pkg::*, ram_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // ==============================
    // Timing and frame geometry
    // ==============================
    localparam int CLK_PERIOD    = 40;
    localparam int PIX_PERIOD    = 56;
    localparam int RESET_CYCLES  = 16;
    localparam int LINE_PIXELS   = 8;
    localparam int LINE_GAP      = 3;
    localparam int FRAME_GAP     = 4;
    localparam int LINES         = `IMAGE_WORDS / LINE_PIXELS;
    // Vertical blanking that lets the FIFO flush finish before the frame
    localparam int SETTLE_CYCLES = 20;
    localparam int DONE_LIMIT    = 200;
    localparam int READY_LIMIT   = 20;

    localparam int FRAME_CYCLES  = 2 * FRAME_GAP + LINES * (LINE_PIXELS + LINE_GAP);
    localparam int FRAME_NS      = (FRAME_CYCLES + SETTLE_CYCLES) * PIX_PERIOD;
    // About 8 clk cycles per word covers the longest readout stalls
    localparam int READ_NS       = `IMAGE_WORDS * 8 * CLK_PERIOD;
    localparam int WATCHDOG_NS   = 6 * FRAME_NS + 7 * READ_NS + 20000;

    // Sample value driven in the blanking gaps of the line blanking test
    localparam pixel_t GAP_MARKER = 12'h5a5;

    logic     clk;
    logic     arst_n;
    logic     cmd_trigger;
    pix_cmd_t cmd;
    logic     busy;
    logic     readout_ready;
    logic     readout_trigger;
    word_t    readout_data;
    logic     readout_done;
    logic     pix_dclk;
    pixel_t   pix_d;
    logic     pix_fv;
    logic     pix_lv;

    integer   seed;
    logic     mark_gaps;
    word_t    expected [`BLOCK_COUNT][`IMAGE_WORDS];

    pix_controller UUT (
        .clk             (clk),
        .arst_n          (arst_n),
        .cmd_trigger     (cmd_trigger),
        .cmd             (cmd),
        .busy            (busy),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .readout_done    (readout_done),
        .pix_dclk        (pix_dclk),
        .pix_d           (pix_d),
        .pix_fv          (pix_fv),
        .pix_lv          (pix_lv)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial pix_dclk = 1'b0;
    always #(PIX_PERIOD / 2) pix_dclk = ~pix_dclk;

    // ==============================
    // Checking
    // ==============================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_value,
                               input logic [31:0] act_value);
        if (act_value !== exp_value) begin
            abort_run($sformatf("ERR %s expected %0h actual %0h", name, exp_value, act_value));
        end
    endtask

    // ==============================
    // Sensor model
    // ==============================
    function automatic pixel_t blank_sample();
        if (mark_gaps) return GAP_MARKER;
        return pixel_t'($random(seed));
    endfunction

    function automatic pixel_t frame_sample();
        pixel_t px;
        px = pixel_t'($random(seed));
        // Keep real pixels distinct from the gap marker
        if (mark_gaps && px == GAP_MARKER) px = px ^ pixel_t'(1);
        return px;
    endfunction

    task automatic drive_sensor(input logic fv, input logic lv, input pixel_t d);
        @(posedge pix_dclk);
        #2;
        pix_fv = fv;
        pix_lv = lv;
        pix_d  = d;
    endtask

    task automatic hold_sensor_idle(input int cycles);
        repeat (cycles) drive_sensor(1'b0, 1'b0, blank_sample());
    endtask

    task automatic send_frame(input int blk, input bit record);
        pixel_t px;
        int     idx;
        idx = 0;
        hold_sensor_idle(FRAME_GAP);
        repeat (LINES) begin
            repeat (LINE_PIXELS) begin
                px = frame_sample();
                if (record) expected[blk][idx] = word_t'(px);
                idx++;
                drive_sensor(1'b1, 1'b1, px);
            end
            // Line blanking keeps fv high
            repeat (LINE_GAP) drive_sensor(1'b1, 1'b0, blank_sample());
        end
        hold_sensor_idle(FRAME_GAP);
    endtask

    `include "pix_tests.svh"

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        seed            = 32'ha5ff_8a2f;
        mark_gaps       = 1'b0;
        arst_n          = 1'b0;
        cmd_trigger     = 1'b0;
        cmd             = '0;
        readout_trigger = 1'b0;
        pix_d           = '0;
        pix_fv          = 1'b0;
        pix_lv          = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
        repeat (4) @(posedge clk);

        test_idle_outputs();
        test_capture_readout();
        test_line_blanking();
        test_skip_partial_frame();
        test_block_isolation();
        test_readout_backpressure();

        $display("No errors");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

/* design/pix_controller.sv */
`default_nettype none

module pix_controller import pix_pkg::*, ram_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n,

    // Command port, clk domain
    input  wire logic     cmd_trigger,
    input  wire pix_cmd_t cmd,
    output logic          busy,

    // Readout port, clk domain
    output logic          readout_ready,
    input  wire logic     readout_trigger,
    output word_t         readout_data,
    output logic          readout_done,

    // Sensor port, pix_dclk domain
    input  wire logic     pix_dclk,
    input  wire pixel_t   pix_d,
    input  wire logic     pix_fv,
    input  wire logic     pix_lv
);

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_flush_wait,
        ctrl_copy,
        ctrl_readout
    } ctrl_state_t;

    ctrl_state_t state;

    // ==============================
    // Capture path
    // ==============================
    logic  capture_toggle;
    logic  flush;
    logic  flush_done;
    logic  flushed;
    logic  wr_en;
    word_t wr_data;
    logic  rd_ready;
    logic  rd_trigger;
    word_t rd_data;

    pix_capture u_capture (
        .pix_dclk       (pix_dclk),
        .arst_n         (arst_n),
        .capture_toggle (capture_toggle),
        .flush_done     (flush_done),
        .pix_d          (pix_d),
        .pix_fv         (pix_fv),
        .pix_lv         (pix_lv),
        .flush          (flush),
        .wr_en          (wr_en),
        .wr_data        (wr_data)
    );

    // Drained faster than the sensor fills it, so wr_ready is left open
    pix_fifo u_fifo (
        .wr_clk     (pix_dclk),
        .rd_clk     (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .rd_trigger (rd_trigger),
        .flush_done (flush_done),
        .flushed    (flushed),
        .wr_ready   (),
        .rd_ready   (rd_ready),
        .rd_data    (rd_data)
    );

    // ==============================
    // Frame memory
    // ==============================
    logic     ram_cmd_trigger;
    ram_cmd_t ram_cmd;
    logic     write_ready;
    logic     write_pending;
    word_t    write_data_q;
    logic     write_done;

    ram_controller u_ram (
        .clk           (clk),
        .arst_n        (arst_n),
        .cmd_trigger   (ram_cmd_trigger),
        .cmd           (ram_cmd),
        .write_trigger (write_pending),
        .write_data    (write_data_q),
        .read_trigger  (readout_trigger),
        .write_ready   (write_ready),
        .write_done    (write_done),
        .read_ready    (readout_ready),
        .read_data     (readout_data),
        .read_done     (readout_done)
    );

    // ==============================
    // Command decode and copy FSM
    // ==============================

    // Pop a new word once the holding register is free or being taken
    assign rd_trigger = (state == ctrl_copy) && (!write_pending || write_ready);
    assign busy       = (state != ctrl_idle);

    always_ff @(posedge clk) begin
        if (rd_ready && rd_trigger) write_data_q <= rd_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= ctrl_idle;
            ram_cmd_trigger <= 1'b0;
            ram_cmd         <= '0;
            capture_toggle  <= 1'b0;
            write_pending   <= 1'b0;
        end else begin
            ram_cmd_trigger <= 1'b0;

            if (cmd_trigger) begin
                ram_cmd_trigger <= 1'b1;
                ram_cmd.write   <= (cmd.op == op_capture);
                ram_cmd.block   <= cmd.block;
                write_pending   <= 1'b0;
                if (cmd.op == op_capture) begin
                    capture_toggle <= ~capture_toggle;
                    state          <= ctrl_flush_wait;
                end else begin
                    state <= ctrl_readout;
                end
            end else begin
                case (state)
                    // Words seen before the flush belong to an older capture
                    ctrl_flush_wait: if (flushed) state <= ctrl_copy;

                    ctrl_copy: begin
                        if (write_pending && write_ready) write_pending <= 1'b0;
                        if (rd_ready && rd_trigger) write_pending <= 1'b1;
                        if (write_done) begin
                            write_pending <= 1'b0;
                            state         <= ctrl_idle;
                        end
                    end

                    // Readout runs on its own once the RAM command is out
                    ctrl_readout: state <= ctrl_idle;

                    default: state <= ctrl_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* design/ram_controller.sv */
`default_nettype none

`include "pix_macros.svh"

module ram_controller import pix_pkg::*, ram_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     cmd_trigger,
    input  wire ram_cmd_t cmd,
    input  wire logic     write_trigger,
    input  wire word_t    write_data,
    input  wire logic     read_trigger,
    output logic          write_ready,
    output logic          write_done,
    output logic          read_ready,
    output word_t         read_data,
    output logic          read_done
);

    localparam int MEM_WORDS = `BLOCK_COUNT * `IMAGE_WORDS;

    // Word offset inside one block
    typedef logic [`ADDR_BITS-`BLOCK_BITS-1:0] count_t;

    localparam count_t LAST_WORD = count_t'(`IMAGE_WORDS - 1);

    word_t      mem [MEM_WORDS];
    ram_state_t state;
    block_t     block_q;
    count_t     count;
    mem_addr_t  addr;
    logic       write_accept;
    logic       read_accept;

    // block * IMAGE_WORDS + count, the block size being a power of two
    assign addr = {block_q, count};

    assign write_ready  = (state == ram_writing);
    assign read_ready   = (state == ram_reading);
    assign write_accept = write_ready && write_trigger;
    assign read_accept  = read_ready && read_trigger;

    // ==============================
    // Storage
    // ==============================
    always_ff @(posedge clk) begin
        if (write_accept) mem[addr] <= write_data;
        if (state == ram_read_fetch) read_data <= mem[addr];
    end

    // ==============================
    // Session FSM
    // ==============================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= ram_idle;
            block_q    <= '0;
            count      <= '0;
            write_done <= 1'b0;
            read_done  <= 1'b0;
        end else begin
            write_done <= 1'b0;
            read_done  <= 1'b0;

            if (cmd_trigger) begin
                // New command drops any session in progress
                state   <= cmd.write ? ram_writing : ram_read_fetch;
                block_q <= cmd.block;
                count   <= '0;
            end else begin
                case (state)
                    ram_writing: begin
                        if (write_accept) begin
                            count <= count + count_t'(1);
                            if (count == LAST_WORD) begin
                                state      <= ram_idle;
                                write_done <= 1'b1;
                            end
                        end
                    end

                    // Memory read takes this cycle
                    ram_read_fetch: state <= ram_reading;

                    ram_reading: begin
                        if (read_accept) begin
                            count <= count + count_t'(1);
                            if (count == LAST_WORD) begin
                                state     <= ram_idle;
                                read_done <= 1'b1;
                            end else begin
                                state <= ram_read_fetch;
                            end
                        end
                    end

                    default: state <= ram_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* design/pix_fifo.sv */
`default_nettype none

`include "pix_macros.svh"

module pix_fifo import pix_pkg::*; (
    input  wire logic  wr_clk,
    input  wire logic  rd_clk,
    input  wire logic  arst_n,
    input  wire logic  flush,
    input  wire logic  wr_en,
    input  wire word_t wr_data,
    input  wire logic  rd_trigger,
    output logic       flush_done,
    output logic       flushed,
    output logic       wr_ready,
    output logic       rd_ready,
    output word_t      rd_data
);

    localparam int DEPTH = 1 << `FIFO_DEPTH_BITS;

    // One extra bit tells full from empty
    typedef logic [`FIFO_DEPTH_BITS:0] ptr_t;

    function automatic ptr_t to_gray(ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    word_t mem [DEPTH];

    ptr_t wr_bin;
    ptr_t wr_gray;
    ptr_t rd_bin;
    ptr_t rd_gray;

    // ==============================
    // Write side, wr_clk
    // ==============================
    ptr_t       rd_gray_s1;
    ptr_t       rd_gray_s2;
    logic       flush_req;
    logic       flush_ack;
    logic [2:0] ack_sync;

    // Full when the pointers differ only in the two top bits
    assign wr_ready = (wr_gray != {~rd_gray_s2[`FIFO_DEPTH_BITS -: 2],
                                   rd_gray_s2[`FIFO_DEPTH_BITS-2:0]});

    always_ff @(posedge wr_clk) begin
        if (wr_en && wr_ready) mem[wr_bin[`FIFO_DEPTH_BITS-1:0]] <= wr_data;
    end

    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_bin    <= '0;
            wr_gray   <= '0;
            flush_req <= 1'b0;
        end else if (flush) begin
            // Clear our pointer and hand the flush over to the read side
            wr_bin    <= '0;
            wr_gray   <= '0;
            flush_req <= ~flush_req;
        end else if (wr_en && wr_ready) begin
            wr_bin  <= wr_bin + ptr_t'(1);
            wr_gray <= to_gray(wr_bin + ptr_t'(1));
        end
    end

    always_ff @(posedge wr_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
            ack_sync   <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
            ack_sync   <= {ack_sync[1:0], flush_ack};
        end
    end

    // Ack arrives together with the cleared read pointer
    assign flush_done = ack_sync[2] ^ ack_sync[1];

    // ==============================
    // Read side, rd_clk
    // ==============================
    ptr_t       wr_gray_s1;
    ptr_t       wr_gray_s2;
    logic [2:0] req_sync;

    assign flushed  = req_sync[2] ^ req_sync[1];
    assign rd_ready = (rd_gray != wr_gray_s2);
    assign rd_data  = mem[rd_bin[`FIFO_DEPTH_BITS-1:0]];

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
            req_sync   <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
            req_sync   <= {req_sync[1:0], flush_req};
        end
    end

    always_ff @(posedge rd_clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_bin    <= '0;
            rd_gray   <= '0;
            flush_ack <= 1'b0;
        end else if (flushed) begin
            rd_bin    <= '0;
            rd_gray   <= '0;
            flush_ack <= ~flush_ack;
        end else if (rd_ready && rd_trigger) begin
            rd_bin  <= rd_bin + ptr_t'(1);
            rd_gray <= to_gray(rd_bin + ptr_t'(1));
        end
    end

endmodule

`default_nettype wire

/* design/pix_capture.sv */
`default_nettype none

module pix_capture import pix_pkg::*; (
    input  wire logic   pix_dclk,
    input  wire logic   arst_n,
    input  wire logic   capture_toggle,
    input  wire logic   flush_done,
    input  wire pixel_t pix_d,
    input  wire logic   pix_fv,
    input  wire logic   pix_lv,
    output logic        flush,
    output logic        wr_en,
    output word_t       wr_data
);

    // ==============================
    // Sensor input registers
    // ==============================

    // First stage samples the pins, second stage lines data up with the FSM
    pixel_t pix_d_q;
    pixel_t pix_d_dly;
    logic   pix_fv_q;
    logic   pix_lv_q;
    logic   pix_lv_dly;

    always_ff @(posedge pix_dclk) begin
        pix_d_q   <= pix_d;
        pix_d_dly <= pix_d_q;
    end

    always_ff @(posedge pix_dclk or negedge arst_n) begin
        if (!arst_n) begin
            pix_fv_q   <= 1'b0;
            pix_lv_q   <= 1'b0;
            pix_lv_dly <= 1'b0;
        end else begin
            pix_fv_q   <= pix_fv;
            pix_lv_q   <= pix_lv;
            pix_lv_dly <= pix_lv_q;
        end
    end

    // ==============================
    // Capture request from clk
    // ==============================
    logic [2:0] toggle_sync;
    logic       start;

    always_ff @(posedge pix_dclk or negedge arst_n) begin
        if (!arst_n) toggle_sync <= '0;
        else         toggle_sync <= {toggle_sync[1:0], capture_toggle};
    end

    assign start = toggle_sync[2] ^ toggle_sync[1];

    // ==============================
    // Capture FSM
    // ==============================
    capture_state_t state;

    always_ff @(posedge pix_dclk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cap_idle;
        end else if (start) begin
            // A new request restarts from scratch whatever we were doing
            state <= cap_flush;
        end else begin
            case (state)
                cap_flush:           state <= cap_flush_wait;
                cap_flush_wait:      if (flush_done) state <= cap_wait_frame_low;
                // Skip whatever frame is already running
                cap_wait_frame_low:  if (!pix_fv_q) state <= cap_wait_frame_high;
                cap_wait_frame_high: if (pix_fv_q) state <= cap_in_frame;
                cap_in_frame:        if (!pix_fv_q) state <= cap_idle;
                default:             state <= cap_idle;
            endcase
        end
    end

    assign flush   = (state == cap_flush);
    assign wr_en   = (state == cap_in_frame) && pix_lv_dly;
    assign wr_data = word_t'(pix_d_dly);

endmodule

`default_nettype wire

/* design/ram_pkg.sv */
`default_nettype none

`include "pix_macros.svh"

package ram_pkg;

    // ==============================
    // Frame memory types
    // ==============================

    typedef logic [`BLOCK_BITS-1:0] block_t;
    typedef logic [`ADDR_BITS-1:0]  mem_addr_t;

    typedef enum logic {
        op_capture,
        op_readout
    } cmd_op_t;

    // Command at the top-level port
    typedef struct packed {
        cmd_op_t op;
        block_t  block;
    } pix_cmd_t;

    // Command into the RAM controller
    typedef struct packed {
        logic   write;
        block_t block;
    } ram_cmd_t;

    typedef enum logic [1:0] {
        ram_idle,
        ram_writing,
        ram_read_fetch,
        ram_reading
    } ram_state_t;

endpackage

`default_nettype wire

/* design/pix_pkg.sv */
`default_nettype none

`include "pix_macros.svh"

package pix_pkg;

    // ==============================
    // Sensor side types
    // ==============================

    // Raw sample as it comes off the sensor bus
    typedef logic [`PIX_WIDTH-1:0] pixel_t;

    // Word as stored in the FIFO and frame memory, pixel zero-extended
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // Capture FSM in the pixel clock domain
    typedef enum logic [2:0] {
        cap_idle,
        cap_flush,
        cap_flush_wait,
        cap_wait_frame_low,
        cap_wait_frame_high,
        cap_in_frame
    } capture_state_t;

endpackage

`default_nettype wire

/* design/pix_macros.svh */
`ifndef PIX_MACROS_SVH
`define PIX_MACROS_SVH

// ==============================
// Sensor and image geometry
// ==============================

// Sensor sample width and stored word width
`define PIX_WIDTH       12
`define WORD_WIDTH      16

// One block holds exactly one captured frame
`define IMAGE_WORDS     64

// ==============================
// Frame memory layout
// ==============================
`define BLOCK_COUNT     8
`define BLOCK_BITS      3
`define ADDR_BITS       9

// Capture FIFO holds 2**FIFO_DEPTH_BITS words
`define FIFO_DEPTH_BITS 3

`endif
